// ==== Bender.yml ====
package:
  name: fabric_hsdom

sources:
  - fabric_pkg.sv
  - fabric_skid_buf.sv
  - fabric_addr_decode.sv
  - fabric_rr_arbiter.sv
  - fabric_order_queue.sv
  - fabric_pause_fsm.sv
  - fabric_hsdom.sv
  - target: test
    files:
      - fabric_tb_target.sv
      - fabric_hsdom_tb.sv

// ==== fabric_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_addr_decode (
    input  logic [fabric_pkg::ADDR_W-1:0] addr,
    output fabric_pkg::slv_idx_t          slv_idx,
    output logic                          dec_err,
    output logic [fabric_pkg::ADDR_W-1:0] local_addr
);

    logic [fabric_pkg::ADDR_W-1:0] offset [fabric_pkg::N_SLV];
    logic [fabric_pkg::N_SLV-1:0]  hit;

    // Window compare
    always_comb begin
        for (int j = 0; j < fabric_pkg::N_SLV; j++) begin
            offset[j] = addr - fabric_pkg::SLV_BASE[j];
            hit[j]    = (addr >= fabric_pkg::SLV_BASE[j]) &&
                        (offset[j] < fabric_pkg::SLV_SIZE[j]);
        end
    end

    always_comb begin
        slv_idx    = '0;
        local_addr = addr;
        dec_err    = 1'b1;
        // Windows are disjoint, lowest index wins anyway
        for (int j = fabric_pkg::N_SLV - 1; j >= 0; j--) begin
            if (hit[j]) begin
                slv_idx    = fabric_pkg::slv_idx_t'(j);
                local_addr = offset[j];
                dec_err    = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fabric_hsdom.f ====
fabric_pkg.sv
fabric_skid_buf.sv
fabric_addr_decode.sv
fabric_rr_arbiter.sv
fabric_order_queue.sv
fabric_pause_fsm.sv
fabric_hsdom.sv
fabric_tb_target.sv
fabric_hsdom_tb.sv

// ==== fabric_hsdom.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_hsdom (
    input  logic                          seq,
    input  logic                          rst,
    // Requester side
    input  logic [fabric_pkg::N_MST-1:0]  m_req_valid,
    input  logic [fabric_pkg::ADDR_W-1:0] m_req_addr  [fabric_pkg::N_MST],
    input  logic [fabric_pkg::N_MST-1:0]  m_req_we,
    input  logic [fabric_pkg::DATA_W-1:0] m_req_wdata [fabric_pkg::N_MST],
    output logic [fabric_pkg::N_MST-1:0]  m_req_ready,
    output logic [fabric_pkg::N_MST-1:0]  m_rsp_valid,
    output logic [fabric_pkg::DATA_W-1:0] m_rsp_rdata [fabric_pkg::N_MST],
    output logic [fabric_pkg::N_MST-1:0]  m_rsp_err,
    input  logic [fabric_pkg::N_MST-1:0]  m_rsp_ready,
    // Target side
    output logic [fabric_pkg::N_SLV-1:0]  s_req_valid,
    output logic [fabric_pkg::ADDR_W-1:0] s_req_addr,
    output logic                          s_req_we,
    output logic [fabric_pkg::DATA_W-1:0] s_req_wdata,
    input  logic [fabric_pkg::N_SLV-1:0]  s_req_ready,
    input  logic [fabric_pkg::N_SLV-1:0]  s_rsp_valid,
    input  logic [fabric_pkg::DATA_W-1:0] s_rsp_rdata [fabric_pkg::N_SLV],
    input  logic [fabric_pkg::N_SLV-1:0]  s_rsp_err,
    output logic [fabric_pkg::N_SLV-1:0]  s_rsp_ready,
    // Pause
    input  logic                          pause_req,
    output logic                          pause_ack
);

    logic [fabric_pkg::N_MST-1:0]  grant;
    fabric_pkg::mst_idx_t          grant_idx;
    logic                          accept;
    logic                          accept_en;
    fabric_pkg::slv_idx_t          dec_slv;
    logic                          dec_err;
    logic [fabric_pkg::ADDR_W-1:0] dec_local;

    fabric_pkg::req_t req_in, req_out;
    logic             req_in_valid, req_in_ready, req_out_valid, req_out_ready;
    fabric_pkg::rsp_t rsp_in, rsp_out;
    logic             rsp_in_valid, rsp_in_ready, rsp_out_valid, rsp_out_ready;

    fabric_pkg::mst_idx_t          head_mst;
    fabric_pkg::slv_idx_t          head_slv;
    logic                          head_err, head_valid, q_full, q_empty, q_pop;
    logic                          drained;
    logic                          tgt_rsp_valid;
    logic [fabric_pkg::DATA_W-1:0] tgt_rsp_rdata;
    logic                          tgt_rsp_err;

    // ========================================
    // Request path
    // ========================================
    fabric_rr_arbiter u_arb (
        .seq       (seq),
        .rst       (rst),
        .req       (m_req_valid),
        .enable    (req_in_ready && !q_full && accept_en),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    assign m_req_ready = grant;
    assign accept      = |grant;

    fabric_addr_decode u_dec (
        .addr       (m_req_addr[grant_idx]),
        .slv_idx    (dec_slv),
        .dec_err    (dec_err),
        .local_addr (dec_local)
    );

    always_comb begin
        req_in.addr  = dec_local;
        req_in.we    = m_req_we[grant_idx];
        req_in.wdata = m_req_wdata[grant_idx];
        req_in.slv   = dec_slv;
        req_in.err   = dec_err;
    end

    assign req_in_valid = accept && !dec_err;  // Errors never reach a target

    fabric_skid_buf #(.payload_t(fabric_pkg::req_t)) u_req_buf (
        .seq       (seq),
        .rst       (rst),
        .in_valid  (req_in_valid),
        .in_ready  (req_in_ready),
        .in_data   (req_in),
        .out_valid (req_out_valid),
        .out_ready (req_out_ready),
        .out_data  (req_out)
    );

    always_comb begin
        for (int j = 0; j < fabric_pkg::N_SLV; j++) begin
            s_req_valid[j] = req_out_valid && (req_out.slv == fabric_pkg::slv_idx_t'(j));
        end
    end

    assign s_req_addr    = req_out.addr;
    assign s_req_we      = req_out.we;
    assign s_req_wdata   = req_out.wdata;
    assign req_out_ready = |(s_req_valid & s_req_ready);

    fabric_order_queue u_oq (
        .seq        (seq),
        .rst        (rst),
        .push       (accept),
        .push_mst   (grant_idx),
        .push_slv   (dec_slv),
        .push_err   (dec_err),
        .pop        (q_pop),
        .head_mst   (head_mst),
        .head_slv   (head_slv),
        .head_err   (head_err),
        .head_valid (head_valid),
        .full       (q_full),
        .empty      (q_empty)
    );

    // ========================================
    // Response path
    // ========================================
    // One response in the buffer at a time, so it always belongs to the head
    always_comb begin
        tgt_rsp_valid = 1'b0;
        tgt_rsp_rdata = '0;
        tgt_rsp_err   = 1'b0;
        for (int j = 0; j < fabric_pkg::N_SLV; j++) begin
            s_rsp_ready[j] = rsp_in_ready && !rsp_out_valid && head_valid && !head_err &&
                             (head_slv == fabric_pkg::slv_idx_t'(j));
            if (head_slv == fabric_pkg::slv_idx_t'(j)) begin
                tgt_rsp_valid = s_rsp_valid[j];
                tgt_rsp_rdata = s_rsp_rdata[j];
                tgt_rsp_err   = s_rsp_err[j];
            end
        end
    end

    assign rsp_in_valid = head_valid && !rsp_out_valid && (head_err || tgt_rsp_valid);
    assign rsp_in.rdata = head_err ? '0 : tgt_rsp_rdata;  // Decode error reads zero
    assign rsp_in.err   = head_err || tgt_rsp_err;

    fabric_skid_buf #(.payload_t(fabric_pkg::rsp_t)) u_rsp_buf (
        .seq       (seq),
        .rst       (rst),
        .in_valid  (rsp_in_valid),
        .in_ready  (rsp_in_ready),
        .in_data   (rsp_in),
        .out_valid (rsp_out_valid),
        .out_ready (rsp_out_ready),
        .out_data  (rsp_out)
    );

    always_comb begin
        for (int i = 0; i < fabric_pkg::N_MST; i++) begin
            m_rsp_valid[i] = rsp_out_valid && (head_mst == fabric_pkg::mst_idx_t'(i));
            m_rsp_rdata[i] = rsp_out.rdata;
            m_rsp_err[i]   = rsp_out.err;
        end
    end

    assign rsp_out_ready = |(m_rsp_valid & m_rsp_ready);
    assign q_pop         = rsp_out_valid && rsp_out_ready;  // Delivered

    // ========================================
    // Pause
    // ========================================
    assign drained = q_empty && !req_out_valid && req_in_ready;

    fabric_pause_fsm u_pause (
        .seq       (seq),
        .rst       (rst),
        .pause_req (pause_req),
        .drained   (drained),
        .accept_en (accept_en),
        .pause_ack (pause_ack)
    );

endmodule

`default_nettype wire

// ==== fabric_hsdom_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_hsdom_tb;

    localparam int TIMEOUT = 300;  // Cycles per wait

    logic        seq = 1'b0;
    logic        rst;
    logic [3:0]  m_req_valid;
    logic [31:0] m_req_addr  [4];
    logic [3:0]  m_req_we;
    logic [31:0] m_req_wdata [4];
    logic [3:0]  m_req_ready;
    logic [3:0]  m_rsp_valid;
    logic [31:0] m_rsp_rdata [4];
    logic [3:0]  m_rsp_err;
    logic [3:0]  m_rsp_ready;
    logic [2:0]  s_req_valid;
    logic [31:0] s_req_addr;
    logic        s_req_we;
    logic [31:0] s_req_wdata;
    wire  [2:0]  s_req_ready;
    wire  [2:0]  s_rsp_valid;
    wire  [31:0] s_rsp_rdata [3];
    wire  [2:0]  s_rsp_err;
    logic [2:0]  s_rsp_ready;
    logic        pause_req;
    logic        pause_ack;
    logic        watch_idle;  // Set while only unmapped addresses are used
    logic [31:0] sb [3][256];  // Expected target memory contents

    always #10 seq = ~seq;

    fabric_hsdom fabric_hsdom_i (
        .seq(seq), .rst(rst),
        .m_req_valid(m_req_valid), .m_req_addr(m_req_addr), .m_req_we(m_req_we),
        .m_req_wdata(m_req_wdata), .m_req_ready(m_req_ready),
        .m_rsp_valid(m_rsp_valid), .m_rsp_rdata(m_rsp_rdata), .m_rsp_err(m_rsp_err),
        .m_rsp_ready(m_rsp_ready),
        .s_req_valid(s_req_valid), .s_req_addr(s_req_addr), .s_req_we(s_req_we),
        .s_req_wdata(s_req_wdata), .s_req_ready(s_req_ready),
        .s_rsp_valid(s_rsp_valid), .s_rsp_rdata(s_rsp_rdata), .s_rsp_err(s_rsp_err),
        .s_rsp_ready(s_rsp_ready),
        .pause_req(pause_req), .pause_ack(pause_ack)
    );

    // Memory fast, bridge slow
    for (genvar j = 0; j < 3; j++) begin : g_tgt
        fabric_tb_target #(.ID(j), .LATENCY(j == 2 ? 8 : j + 1)) u_tgt (
            .seq(seq), .rst(rst),
            .req_valid(s_req_valid[j]), .req_ready(s_req_ready[j]),
            .req_addr(s_req_addr), .req_we(s_req_we), .req_wdata(s_req_wdata),
            .rsp_valid(s_rsp_valid[j]), .rsp_ready(s_rsp_ready[j]),
            .rsp_rdata(s_rsp_rdata[j]), .rsp_err(s_rsp_err[j])
        );
    end

    // ========================================
    // Helpers
    // ========================================
    task fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Expected read data, writes update the model
    // Window bases are 1 KiB aligned, so the low address bits pick the word
    function logic [31:0] model_access(input logic [31:0] addr, input logic we,
                                       input logic [31:0] wdata);
        logic [31:0] last;
        model_access = '0;
        for (int j = 0; j < 3; j++) begin
            last = fabric_pkg::SLV_BASE[j] + fabric_pkg::SLV_SIZE[j] - 1;
            if (addr >= fabric_pkg::SLV_BASE[j] && addr <= last) begin
                if (we) sb[j][addr[9:2]] = wdata;
                else model_access = sb[j][addr[9:2]];
            end
        end
    endfunction

    task send_req(input int mst, input logic [31:0] addr, input logic we,
                  input logic [31:0] wdata);
        int n;
        @(posedge seq);
        m_req_valid[mst] <= 1'b1;
        m_req_addr[mst]  <= addr;
        m_req_we[mst]    <= we;
        m_req_wdata[mst] <= wdata;
        n = 0;
        do begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for the fabric to accept a request");
        end while (!m_req_ready[mst]);
        @(posedge seq);  // Transfer edge
        m_req_valid[mst] <= 1'b0;
    endtask

    task recv_rsp(input int mst, input logic [31:0] exp_rdata, input logic exp_err);
        int n;
        @(posedge seq);
        m_rsp_ready[mst] <= 1'b1;
        n = 0;
        do begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for a response");
        end while (!m_rsp_valid[mst]);
        compare("m_rsp_rdata", m_rsp_rdata[mst], exp_rdata);
        compare("m_rsp_err", m_rsp_err[mst], exp_err);
        @(posedge seq);
        m_rsp_ready[mst] <= 1'b0;
    endtask

    task access(input int mst, input logic [31:0] addr, input logic we,
                input logic [31:0] wdata, input logic exp_err);
        logic [31:0] exp;
        exp = model_access(addr, we, wdata);
        send_req(mst, addr, we, wdata);
        recv_rsp(mst, exp, exp_err);
    endtask

    // ========================================
    // Tests
    // ========================================
    task each_window_rw();
        logic [31:0] a;
        logic [31:0] d;
        for (int m = 0; m < 4; m++) begin
            for (int w = 0; w < 3; w++) begin
                for (int e = 0; e < 2; e++) begin
                    a = fabric_pkg::SLV_BASE[w] + (e == 1 ? fabric_pkg::SLV_SIZE[w] - 4 : 0);
                    d = 32'hD000_0000 | (m << 20) | (w << 16) | a[15:0];
                    access(m, a, 1'b1, d, 1'b0);
                    access(m, a, 1'b0, '0, 1'b0);
                end
            end
        end
    endtask

    task decode_error_rsp();
        watch_idle = 1'b1;
        access(3, 32'h0100_0000, 1'b0, '0, 1'b1);
        access(0, 32'h0400_0000, 1'b1, 32'hBAD0_0001, 1'b1);
        access(2, 32'h0400_0000, 1'b0, '0, 1'b1);
        watch_idle = 1'b0;
    endtask

    // Slow bridge first, fast memory second
    task response_ordering();
        logic [31:0] e0;
        logic [31:0] e1;
        e0 = model_access(fabric_pkg::SLV_BASE[2] + 32'h40, 1'b0, '0);
        e1 = model_access(fabric_pkg::SLV_BASE[0] + 32'h40, 1'b0, '0);
        send_req(1, fabric_pkg::SLV_BASE[2] + 32'h40, 1'b0, '0);
        send_req(1, fabric_pkg::SLV_BASE[0] + 32'h40, 1'b0, '0);
        recv_rsp(1, e0, 1'b0);
        recv_rsp(1, e1, 1'b0);
    endtask

    task round_robin_grants();
        int order [12];
        int accepted;
        int delivered;
        int n;
        logic [3:0] mask;
        @(posedge seq);
        for (int i = 0; i < 4; i++) begin
            m_req_valid[i] <= 1'b1;
            m_req_addr[i]  <= 32'h0000_0100 + i * 4;
            m_req_we[i]    <= 1'b0;
        end
        m_rsp_ready <= 4'hF;
        accepted  = 0;
        delivered = 0;
        n         = 0;
        while (delivered < 12) begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Timed out during the arbitration test");
            if (m_rsp_valid != '0) begin
                compare("m_rsp_err", m_rsp_err & m_rsp_valid, '0);
                delivered++;
            end
            if (m_req_ready != '0) begin
                compare("m_req_ready one-hot", m_req_ready & (m_req_ready - 1'b1), '0);
                for (int i = 0; i < 4; i++) begin
                    if (m_req_ready[i]) order[accepted] = i;
                end
                accepted++;
                if (accepted >= 4) begin
                    mask = '0;
                    for (int t = accepted - 4; t < accepted; t++) mask[order[t]] = 1'b1;
                    compare("grant window", mask, 4'hF);
                end
                if (accepted == 12) begin
                    @(posedge seq);
                    m_req_valid <= '0;
                end
            end
        end
        @(posedge seq);
        m_rsp_ready <= '0;
    endtask

    task pause_drain();
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] e2;
        int n;
        int got;
        e0 = model_access(fabric_pkg::SLV_BASE[2] + 32'h80, 1'b0, '0);
        e1 = model_access(fabric_pkg::SLV_BASE[0] + 32'h80, 1'b0, '0);
        e2 = model_access(fabric_pkg::SLV_BASE[0] + 32'h84, 1'b0, '0);
        send_req(0, fabric_pkg::SLV_BASE[2] + 32'h80, 1'b0, '0);
        send_req(0, fabric_pkg::SLV_BASE[0] + 32'h80, 1'b0, '0);
        @(posedge seq);
        pause_req      <= 1'b1;
        m_req_valid[1] <= 1'b1;  // Must stay blocked
        m_req_addr[1]  <= fabric_pkg::SLV_BASE[0] + 32'h84;
        m_req_we[1]    <= 1'b0;
        m_rsp_ready[0] <= 1'b1;
        n   = 0;
        got = 0;
        while (!pause_ack) begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for pause_ack");
            if (m_req_ready != '0) fail_run("A request was accepted while pause_req was high");
            if (pause_ack && got < 2) fail_run("pause_ack rose with responses still outstanding");
            if (m_rsp_valid[0]) begin
                compare("m_rsp_rdata", m_rsp_rdata[0], got == 0 ? e0 : e1);
                got++;
            end
        end
        repeat (5) begin
            @(negedge seq);
            if (m_req_ready != '0) fail_run("A request was accepted while paused");
        end
        @(posedge seq);
        pause_req      <= 1'b0;
        m_rsp_ready[0] <= 1'b0;
        n = 0;
        do begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Traffic did not resume after pause_req fell");
        end while (!m_req_ready[1]);
        @(posedge seq);
        m_req_valid[1] <= 1'b0;
        recv_rsp(1, e2, 1'b0);
    endtask

    task response_backpressure();
        logic [31:0] exp;
        logic [31:0] held;
        int n;
        access(2, fabric_pkg::SLV_BASE[1] + 32'h8, 1'b1, 32'h5A5A_0002, 1'b0);
        exp = model_access(fabric_pkg::SLV_BASE[1] + 32'h8, 1'b0, '0);
        send_req(2, fabric_pkg::SLV_BASE[1] + 32'h8, 1'b0, '0);
        n = 0;
        do begin
            @(negedge seq);
            n++;
            if (n > TIMEOUT) fail_run("Timed out waiting for a stalled response");
        end while (!m_rsp_valid[2]);
        held = m_rsp_rdata[2];
        repeat (30) begin
            @(negedge seq);
            compare("m_rsp_valid", m_rsp_valid[2], 1'b1);
            compare("m_rsp_rdata", m_rsp_rdata[2], held);
        end
        recv_rsp(2, exp, 1'b0);
    endtask

    // Requests to unmapped addresses must never reach a target
    always @(negedge seq) begin
        if (watch_idle && s_req_valid != '0) begin
            fail_run("A target saw a request for an unmapped address");
        end
        for (int j = 0; j < 3; j++) begin
            if (s_req_valid[j] && s_req_addr >= fabric_pkg::SLV_SIZE[j]) begin  // Local offset
                fail_run($sformatf("Target %0d got address 0x%08h beyond its window size",
                                   j, s_req_addr));
            end
        end
    end

    initial begin
        rst         = 1'b1;
        pause_req   = 1'b0;
        m_req_valid = '0;
        m_req_we    = '0;
        m_rsp_ready = '0;
        watch_idle  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_req_addr[i]  = '0;
            m_req_wdata[i] = '0;
        end
        for (int j = 0; j < 3; j++) begin
            for (int k = 0; k < 256; k++) sb[j][k] = {8'(j + 1), 8'hC0, 8'(k), ~8'(k)};
        end
        repeat (4) @(posedge seq);
        rst <= 1'b0;
        each_window_rw();
        decode_error_rsp();
        response_ordering();
        round_robin_grants();
        pause_drain();
        response_backpressure();
        repeat (5) @(posedge seq);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fabric_order_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_order_queue (
    input  logic                 seq,
    input  logic                 rst,
    input  logic                 push,
    input  fabric_pkg::mst_idx_t push_mst,
    input  fabric_pkg::slv_idx_t push_slv,
    input  logic                 push_err,
    input  logic                 pop,
    output fabric_pkg::mst_idx_t head_mst,
    output fabric_pkg::slv_idx_t head_slv,
    output logic                 head_err,
    output logic                 head_valid,
    output logic                 full,
    output logic                 empty
);

    fabric_pkg::mst_idx_t mst_q [fabric_pkg::MAX_TRANS];
    fabric_pkg::slv_idx_t slv_q [fabric_pkg::MAX_TRANS];
    logic                 err_q [fabric_pkg::MAX_TRANS];

    logic [$clog2(fabric_pkg::MAX_TRANS)-1:0]   wr_ptr;
    logic [$clog2(fabric_pkg::MAX_TRANS)-1:0]   rd_ptr;
    logic [$clog2(fabric_pkg::MAX_TRANS+1)-1:0] count;
    logic                                       do_push;
    logic                                       do_pop;

    // Depth is not a power of two
    function automatic logic [$clog2(fabric_pkg::MAX_TRANS)-1:0] next_ptr(
        input logic [$clog2(fabric_pkg::MAX_TRANS)-1:0] ptr
    );
        return (ptr == fabric_pkg::MAX_TRANS - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge seq) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge seq) begin
        if (do_push) begin
            mst_q[wr_ptr] <= push_mst;
            slv_q[wr_ptr] <= push_slv;
            err_q[wr_ptr] <= push_err;
        end
    end

    assign head_mst   = mst_q[rd_ptr];
    assign head_slv   = slv_q[rd_ptr];
    assign head_err   = err_q[rd_ptr];
    assign full       = (count == fabric_pkg::MAX_TRANS);
    assign empty      = (count == 0);
    assign head_valid = !empty;

endmodule

`default_nettype wire

// ==== fabric_pause_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_pause_fsm (
    input  logic seq,
    input  logic rst,
    input  logic pause_req,
    input  logic drained,
    output logic accept_en,
    output logic pause_ack
);

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        PAUSED
    } state_t;

    state_t state;
    state_t state_d;

    always_comb begin
        state_d = state;
        case (state)
            RUN: begin
                if (pause_req) state_d = DRAIN;
            end
            DRAIN: begin
                if (!pause_req) state_d = RUN;  // Request withdrawn
                else if (drained) state_d = PAUSED;
            end
            PAUSED: begin
                if (!pause_req) state_d = RUN;
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge seq) begin
        if (rst) state <= RUN;
        else state <= state_d;
    end

    // Stop acceptance in the same cycle pause_req rises
    assign accept_en = (state == RUN) && !pause_req;
    assign pause_ack = (state == PAUSED);

endmodule

`default_nettype wire

// ==== fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

    // ========================================
    // Widths and counts
    // ========================================
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int N_MST     = 4;  // cpu0, cpu1, dma, debug
    localparam int N_SLV     = 3;  // mem, periph, bridge
    localparam int MAX_TRANS = 7;

    // ========================================
    // Address map
    // ========================================
    localparam logic [ADDR_W-1:0] SLV_BASE [N_SLV] = '{
        32'h0000_0000,  // memory
        32'h0200_0000,  // peripheral window
        32'h0300_0000   // bridge toward low-speed domain
    };

    localparam logic [ADDR_W-1:0] SLV_SIZE [N_SLV] = '{
        32'h0100_0000,
        32'h0000_0400,
        32'h0008_0000
    };

    typedef logic [$clog2(N_MST)-1:0] mst_idx_t;
    typedef logic [1:0]               slv_idx_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;  // Target-local offset
        logic              we;
        logic [DATA_W-1:0] wdata;
        slv_idx_t          slv;
        logic              err;   // Decode error
    } req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } rsp_t;

endpackage

`default_nettype wire

// ==== fabric_rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_rr_arbiter (
    input  logic                           seq,
    input  logic                           rst,
    input  logic [fabric_pkg::N_MST-1:0]   req,
    input  logic                           enable,
    output logic [fabric_pkg::N_MST-1:0]   grant,
    output fabric_pkg::mst_idx_t           grant_idx
);

    fabric_pkg::mst_idx_t last_idx;  // Last granted requester
    fabric_pkg::mst_idx_t cand;
    logic                 found;

    // ========================================
    // Search starting after last grant
    // ========================================
    always_comb begin
        found     = 1'b0;
        grant_idx = last_idx;
        cand      = last_idx;
        for (int k = 1; k <= fabric_pkg::N_MST; k++) begin
            cand = fabric_pkg::mst_idx_t'((int'(last_idx) + k) % fabric_pkg::N_MST);
            if (!found && req[cand]) begin
                found     = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (enable && found) grant[grant_idx] = 1'b1;
    end

    // Pointer only moves on a real grant
    always_ff @(posedge seq) begin
        if (rst) begin
            last_idx <= fabric_pkg::mst_idx_t'(fabric_pkg::N_MST - 1);  // Index 0 first
        end else if (|grant) begin
            last_idx <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== fabric_skid_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_skid_buf #(
    parameter type payload_t = logic
) (
    input  logic     seq,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t skid_data;
    logic     skid_valid;
    logic     skid_valid_d;
    logic     out_valid_d;
    logic     in_fire;

    assign in_fire = in_valid && in_ready;

    always_comb begin
        out_valid_d  = out_valid;
        skid_valid_d = skid_valid;
        if (!out_valid || out_ready) begin
            if (skid_valid) begin  // Drain the skid entry first
                out_valid_d  = 1'b1;
                skid_valid_d = 1'b0;
            end else begin
                out_valid_d = in_fire;
            end
        end else if (in_fire) begin
            skid_valid_d = 1'b1;  // Output stalled
        end
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_d;
            skid_valid <= skid_valid_d;
            in_ready   <= !skid_valid_d;
        end
    end

    always_ff @(posedge seq) begin
        if (!out_valid || out_ready) out_data <= skid_valid ? skid_data : in_data;
        if (out_valid && !out_ready && in_fire) skid_data <= in_data;
    end

endmodule

`default_nettype wire

// ==== fabric_tb_target.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_tb_target #(
    parameter int ID      = 0,
    parameter int LATENCY = 1
) (
    input  logic        seq,
    input  logic        rst,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] req_addr,
    input  logic        req_we,
    input  logic [31:0] req_wdata,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_rdata,
    output logic        rsp_err
);

    logic [31:0] mem [256];
    logic        busy;
    int          wait_cnt;
    integer      seed;

    initial begin
        seed = 90;
        for (int k = 0; k < 256; k++) begin
            mem[k] = {8'(ID + 1), 8'hC0, 8'(k), ~8'(k)};  // Tagged with target and index
        end
    end

    // One transaction at a time, random stalls on both handshakes
    always @(posedge seq) begin
        if (rst) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_rdata <= '0;
            rsp_err   <= 1'b0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
        end else if (!busy) begin
            if (req_valid && req_ready) begin
                busy      <= 1'b1;
                req_ready <= 1'b0;
                wait_cnt  <= LATENCY;
                if (req_we) begin
                    mem[req_addr[9:2]] <= req_wdata;
                    rsp_rdata          <= '0;
                end else begin
                    rsp_rdata <= mem[req_addr[9:2]];
                end
            end else begin
                req_ready <= ($random(seed) % 4) != 0;
            end
        end else if (rsp_valid) begin
            if (rsp_ready) begin
                rsp_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end else if (wait_cnt > 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            rsp_valid <= ($random(seed) % 3) != 0;
        end
    end

endmodule

`default_nettype wire
